//--- alu_wb.f
+incdir+.
alu_pkg.sv
alu_comb.sv
alu_mul_seq.sv
alu_step_counter.sv
alu_ctrl_fsm.sv
alu_regs.sv
alu_wb_top.sv
tb_alu_wb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_alu_wb
FILELIST  ?= alu_wb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 ; cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "ALL TESTS PASSED" $(LOG) || (echo "no pass line in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- alu_stimulus.txt
# kind adr data lat, all hex: W writes data to adr, R reads adr and expects data
# lat is the number of clocks from driving the request to seeing ack
R 4 ff 01
R 2 20 01
W 0 7f 01
W 1 01 01
W 2 29 01
R 3 80 01
R 4 c6 01
W 0 ff 01
W 2 09 01
R 3 01 01
R 4 76 01
W 0 10 01
W 1 20 01
W 2 0a 01
R 3 ef 01
R 4 5a 01
W 2 2b 01
R 3 10 01
R 4 fa 01
W 0 80 01
W 2 23 01
R 3 80 01
R 4 c6 01
W 0 01 01
W 2 23 01
R 3 ff 01
R 4 da 01
W 0 00 01
W 2 27 01
R 3 ff 01
R 4 5a 01
W 2 22 01
R 3 00 01
R 4 ba 01
W 0 90 01
W 1 10 01
W 2 39 01
R 3 10 01
R 4 f6 01
W 2 3a 01
R 3 90 01
R 4 d6 01
W 1 90 01
W 2 3a 01
R 3 90 01
R 4 dd 01
W 0 10 01
W 2 39 01
R 3 10 01
R 4 fa 01
W 0 c8 01
W 1 03 01
W 2 30 0b
R 3 02 01
R 4 f6 01
W 2 31 0b
R 3 58 01
R 4 76 01
W 0 05 01
W 1 06 01
W 2 31 0b
R 3 1e 01
R 4 fa 01
W 0 33 01
W 1 44 01
R 3 1e 01
R 4 fa 01
W 2 34 0b
R 3 00 01
R 4 ba 01

//--- tb_alu_wb.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_defs.svh"

module tb_alu_wb;
    import alu_pkg::*;

    logic              clk;
    logic              rst_n;
    wb_req_t           req;
    logic [`ALU_W-1:0] dat_r;
    logic              ack;

    int cycle_cnt   = 0;
    int cycle_limit = 100000;  // replaced once the stimulus length is known

    // one entry per stimulus line
    logic [7:0] kind_q[$];
    logic [7:0] adr_q[$];
    logic [7:0] data_q[$];
    logic [7:0] lat_q[$];

    alu_wb_top alu_wb_top_i (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .dat_r (dat_r),
        .ack   (ack)
    );

    always #20 clk = ~clk;  // 40 ns period

    // watchdog so a missing ack cannot stall the run
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout: the run went past %0d cycles, a bus transfer never got its ack",
                     cycle_limit);
            $display("SOME TESTS FAILED");
            $fatal(1, "timeout");
        end
    end

    task automatic check_val(input logic [7:0] got, input logic [7:0] expected, input string what);
        if (got !== expected) begin
            $display("ERR %0t: %s got %02h expected %02h", $time, what, got, expected);
            $display("SOME TESTS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // holds one Wishbone classic request until ack is seen
    task automatic bus_xfer(input logic we, input logic [2:0] adr, input logic [7:0] wdat,
                            output logic [7:0] rdat, output int cycles);
        @(posedge clk);
        req.cyc   <= 1'b1;
        req.stb   <= 1'b1;
        req.we    <= we;
        req.adr   <= adr;
        req.dat_w <= wdat;
        cycles = 0;
        @(negedge clk);  // outputs are looked at mid-cycle where they have settled
        while (ack !== 1'b1) begin
            @(negedge clk);
            cycles++;
        end
        rdat = dat_r;  // read mux follows the held address
        @(posedge clk);
        req.cyc <= 1'b0;  // ack seen on this edge so the request drops
        req.stb <= 1'b0;
        req.we  <= 1'b0;
        @(negedge clk);  // ack is a single cycle pulse
        check_val({7'b0, ack}, 8'h00, "ack in the cycle after the transfer");
    endtask

    // pull every usable line of the stimulus file into the queues
    task automatic load_stimulus();
        int         fd;
        int         rc;
        int         fields;
        string      line;
        logic [7:0] kind;
        logic [7:0] adr;
        logic [7:0] data;
        logic [7:0] lat;
        fd = $fopen("alu_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open alu_stimulus.txt for reading");
            $display("SOME TESTS FAILED");
            $fatal(1, "no stimulus file");
        end
        while (!$feof(fd)) begin
            line = "";
            rc   = $fgets(line, fd);
            if (rc > 0 && line.len() > 3 && line.getc(0) != "#") begin  // skips notes and blanks
                fields = $sscanf(line, "%c %h %h %h", kind, adr, data, lat);
                if (fields != 4) begin
                    $display("stimulus line could not be parsed: %s", line);
                    $display("SOME TESTS FAILED");
                    $fatal(1, "bad stimulus line");
                end
                kind_q.push_back(kind);
                adr_q.push_back(adr);
                data_q.push_back(data);
                lat_q.push_back(lat);
            end
        end
        $fclose(fd);
    endtask

    initial begin
        logic [7:0] rdat;
        int         cycles;
        clk   = 1'b0;
        rst_n <= 1'b0;
        req   <= '0;
        load_stimulus();
        if (kind_q.size() == 0) begin
            $display("alu_stimulus.txt holds no transfers to run");
            $display("SOME TESTS FAILED");
            $fatal(1, "empty stimulus");
        end
        cycle_limit = 20 * kind_q.size() + 8;  // generous even for a string of multiplies
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < kind_q.size(); i++) begin
            if (kind_q[i] == "W") begin
                bus_xfer(1'b1, adr_q[i][2:0], data_q[i], rdat, cycles);
            end else if (kind_q[i] == "R") begin
                bus_xfer(1'b0, adr_q[i][2:0], 8'h00, rdat, cycles);
                check_val(rdat, data_q[i], $sformatf("entry %0d read of reg %0d", i, adr_q[i]));
            end else begin
                $display("entry %0d has an unknown transfer kind, only W and R exist", i);
                $display("SOME TESTS FAILED");
                $fatal(1, "bad transfer kind");
            end
            // ack latency separates plain accesses from the sequential multiply
            check_val(8'(cycles), lat_q[i], $sformatf("entry %0d ack latency", i));
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- alu_wb_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_defs.svh"

module alu_wb_top (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire alu_pkg::wb_req_t req,
    output logic [`ALU_W-1:0]     dat_r,
    output logic                  ack
);
    import alu_pkg::*;

    logic [`ALU_W-1:0]   a;
    logic [`ALU_W-1:0]   b;
    alu_cmd_t            cmd;
    logic [`ALU_W-1:0]   result;
    alu_flags_t          flags;
    logic [2*`ALU_W-1:0] product;
    logic                reg_we;
    logic                start;
    logic                load;
    logic                is_mul;
    logic                last_step;

    alu_regs alu_regs_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .req    (req),
        .reg_we (reg_we),
        .load   (load),
        .result (result),
        .flags  (flags),
        .a      (a),
        .b      (b),
        .cmd    (cmd),
        .is_mul (is_mul),
        .dat_r  (dat_r)
    );

    alu_ctrl_fsm alu_ctrl_fsm_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .is_mul    (is_mul),
        .last_step (last_step),
        .reg_we    (reg_we),
        .start     (start),
        .load      (load),
        .ack       (ack)
    );

    // counter and multiplier share the launch strobe so they stay in step
    alu_step_counter alu_step_counter_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .last_step (last_step)
    );

    alu_mul_seq alu_mul_seq_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (start),
        .a       (a),
        .b       (b),
        .product (product)
    );

    alu_comb alu_comb_i (
        .a       (a),
        .b       (b),
        .cmd     (cmd),
        .product (product),
        .result  (result),
        .flags   (flags)
    );

endmodule

`default_nettype wire

//--- alu_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_defs.svh"

module alu_regs (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire alu_pkg::wb_req_t    req,
    input  wire logic                reg_we,
    input  wire logic                load,
    input  wire logic [`ALU_W-1:0]   result,
    input  wire alu_pkg::alu_flags_t flags,
    output logic [`ALU_W-1:0]        a,
    output logic [`ALU_W-1:0]        b,
    output alu_pkg::alu_cmd_t        cmd,
    output logic                     is_mul,
    output logic [`ALU_W-1:0]        dat_r
);
    import alu_pkg::*;

    logic [`ALU_W-1:0] res_q;
    alu_flags_t        flags_q;
    alu_op_word_u      wr_op;     // op field of the byte being written
    logic              op_write;

    // op resets to pass A with cin_n high and every flag starts inactive
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmd     <= alu_cmd_t'(`ALU_OP_RESET);
            flags_q <= alu_flags_t'(`ALU_FLAGS_RESET);
        end else begin
            if (reg_we && (req.adr == `ALU_ADDR_OP)) begin
                cmd <= alu_cmd_t'(req.dat_w);
            end
            if (load) begin
                flags_q <= flags;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reg_we && (req.adr == `ALU_ADDR_A)) begin
            a <= req.dat_w;
        end
        if (reg_we && (req.adr == `ALU_ADDR_B)) begin
            b <= req.dat_w;
        end
        if (load) begin
            res_q <= result;  // operand writes alone leave the old result standing
        end
    end

    // the FSM picks its path in the sampling cycle so the class comes straight off the bus
    assign op_write = req.cyc && req.stb && req.we && (req.adr == `ALU_ADDR_OP);
    assign wr_op    = alu_op_word_u'(req.dat_w[4:0]);
    assign is_mul   = op_write && (wr_op.f.op_class == 2'd2);

    always_comb begin
        case (req.adr)
            `ALU_ADDR_A:     dat_r = a;
            `ALU_ADDR_B:     dat_r = b;
            `ALU_ADDR_OP:    dat_r = cmd;
            `ALU_ADDR_RES:   dat_r = res_q;
            `ALU_ADDR_FLAGS: dat_r = flags_q;
            default:         dat_r = '0;  // unmapped addresses read as zero
        endcase
    end

endmodule

`default_nettype wire

//--- alu_ctrl_fsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_defs.svh"

module alu_ctrl_fsm (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire alu_pkg::wb_req_t req,
    input  wire logic             is_mul,
    input  wire logic             last_step,
    output logic                  reg_we,
    output logic                  start,
    output logic                  load,
    output logic                  ack
);
    import alu_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        ACCESS,   // ack cycle
        MUL_RUN,  // waiting on the shift-add multiplier
        DONE      // ack low gap before the next transfer is taken
    } state_e;

    state_e state;
    logic   op_wr;  // the transfer in ACCESS was an operation write still to be loaded
    logic   req_v;
    logic   op_hit;

    assign req_v  = req.cyc && req.stb;
    assign op_hit = req.we && (req.adr == `ALU_ADDR_OP);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            start <= 1'b0;
            op_wr <= 1'b0;
        end else begin
            start <= 1'b0;  // launch strobe is a single cycle
            case (state)
                IDLE: begin
                    if (req_v && op_hit && is_mul) begin
                        state <= MUL_RUN;
                        start <= 1'b1;
                    end else if (req_v) begin
                        state <= ACCESS;
                        op_wr <= op_hit;
                    end
                end
                MUL_RUN: begin
                    if (last_step) begin
                        state <= ACCESS;
                        op_wr <= 1'b0;  // the product is captured on the way out of here
                    end
                end
                ACCESS:  state <= DONE;
                default: state <= IDLE;  // a stb still held high is then taken as the next transfer
            endcase
        end
    end

    assign reg_we = (state == IDLE) && req_v && req.we;  // register written as the request is sampled
    assign load   = ((state == ACCESS) && op_wr) || ((state == MUL_RUN) && last_step);
    assign ack    = (state == ACCESS);

endmodule

`default_nettype wire

//--- alu_step_counter.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_defs.svh"

module alu_step_counter (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic start,
    output logic      last_step
);

    logic [3:0] count;  // steps still to go, wide enough for ALU_MUL_STEPS

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count     <= '0;
            last_step <= 1'b0;
        end else if (start) begin
            count     <= 4'(`ALU_MUL_STEPS);
            last_step <= 1'b0;
        end else begin
            if (count != '0) begin
                count <= count - 4'd1;
            end
            last_step <= (count == 4'd1);  // high for the cycle after the eighth step
        end
    end

endmodule

`default_nettype wire

//--- alu_mul_seq.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_defs.svh"

module alu_mul_seq (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                start,
    input  wire logic [`ALU_W-1:0]   a,
    input  wire logic [`ALU_W-1:0]   b,
    output logic [2*`ALU_W-1:0]      product
);

    logic [2*`ALU_W-1:0] mcand;   // multiplicand that moves one place left per step
    logic [`ALU_W-1:0]   mplier;  // multiplier whose low bit decides each add
    logic [2*`ALU_W-1:0] acc;

    // start clears the accumulator and takes the multiplier from b
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc    <= '0;
            mplier <= '0;
        end else if (start) begin
            acc    <= '0;
            mplier <= b;
        end else begin
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            // once every bit is shifted out nothing more is added and the product holds
            mplier <= mplier >> 1;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            mcand <= {{`ALU_W{1'b0}}, a};
        end else begin
            mcand <= mcand << 1;  // weight doubles with every multiplier bit
        end
    end

    assign product = acc;

endmodule

`default_nettype wire

//--- alu_comb.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_defs.svh"

module alu_comb (
    input  wire logic [`ALU_W-1:0]   a,
    input  wire logic [`ALU_W-1:0]   b,
    input  wire alu_pkg::alu_cmd_t   cmd,
    input  wire logic [2*`ALU_W-1:0] product,
    output logic [`ALU_W-1:0]        result,
    output alu_pkg::alu_flags_t      flags
);
    import alu_pkg::*;

    logic [`ALU_W:0]   a9;    // operands widened so bit 8 catches carry or borrow
    logic [`ALU_W:0]   b9;
    logic [`ALU_W:0]   cin9;
    logic [`ALU_W:0]   tmp;   // result in the low byte, carry in the top bit
    logic              ovf;
    logic [`ALU_W-1:0] prod_hi;
    logic [`ALU_W-1:0] prod_lo;

    assign a9      = {1'b0, a};
    assign b9      = {1'b0, b};
    assign cin9    = {{`ALU_W{1'b0}}, ~cmd.cin_n};  // only the two-operand add and subtracts use it
    assign prod_hi = product[2*`ALU_W-1:`ALU_W];
    assign prod_lo = product[`ALU_W-1:0];

    always_comb begin
        tmp = '0;  // undefined codes fall out as zero with carry clear
        ovf = 1'b0;
        case (cmd.op.code)
            PASS_A: tmp = a9;
            PASS_B: tmp = b9;
            ZERO:   tmp = '0;
            NEG_A: begin
                tmp = {1'b0, 8'h00 - a};  // negate never reports carry
                ovf = (a == 8'h80);       // -128 has no positive twin
            end
            NEG_B: begin
                tmp = {1'b0, 8'h00 - b};
                ovf = (b == 8'h80);
            end
            A_PLUS_1:  tmp = a9 + 9'd1;  // carry out when a wraps from FF
            B_PLUS_1:  tmp = b9 + 9'd1;
            A_MINUS_1: tmp = a9 - 9'd1;  // borrow lands in bit 8 when a is zero
            B_MINUS_1: tmp = b9 - 9'd1;
            A_PLUS_B: begin
                tmp = a9 + b9 + cin9;
                // two like-signed inputs giving the other sign is an overflow
                ovf = (a[7] == b[7]) && (tmp[7] != a[7]);
            end
            A_MINUS_B: begin
                tmp = a9 - b9 - cin9;
                ovf = (a[7] != b[7]) && (tmp[7] != a[7]);  // sign now unlike the minuend
            end
            B_MINUS_A: begin
                tmp = b9 - a9 - cin9;
                ovf = (a[7] != b[7]) && (tmp[7] != b[7]);
            end
            MUL_HI, MUL_LO: begin
                // op_sel bit 0 picks the low byte, which also reports a nonzero high byte
                if (cmd.op.f.op_sel[0]) begin
                    tmp = {(prod_hi != 8'h00), prod_lo};
                end else begin
                    tmp = {1'b0, prod_hi};
                end
            end
            AND:     tmp = a9 & b9;
            OR:      tmp = a9 | b9;
            default: tmp = '0;
        endcase
    end

    assign result = tmp[`ALU_W-1:0];

    // everything goes out inverted, z and n follow the result byte
    always_comb begin
        flags.c_n  = ~tmp[`ALU_W];
        flags.z_n  = ~(result == '0);
        flags.n_n  = ~result[`ALU_W-1];
        flags.o_n  = ~ovf;
        // compares are plain unsigned magnitude on the inputs, whatever the op
        flags.gt_n = ~(a > b);
        flags.lt_n = ~(a < b);
        flags.eq_n = ~(a == b);
        flags.ne_n = ~(a != b);
    end

endmodule

`default_nettype wire

//--- alu_pkg.sv
`default_nettype none

`include "alu_defs.svh"

package alu_pkg;

    // five-bit op codes, the gaps between the groups are undefined and give zero
    typedef enum logic [4:0] {
        PASS_A    = 5'd0,
        PASS_B    = 5'd1,
        ZERO      = 5'd2,
        NEG_A     = 5'd3,
        NEG_B     = 5'd4,
        A_PLUS_1  = 5'd5,
        B_PLUS_1  = 5'd6,
        A_MINUS_1 = 5'd7,
        B_MINUS_1 = 5'd8,
        A_PLUS_B  = 5'd9,
        A_MINUS_B = 5'd10,
        B_MINUS_A = 5'd11,
        MUL_HI    = 5'd16,
        MUL_LO    = 5'd17,
        AND       = 5'd25,
        OR        = 5'd26
    } alu_op_e;

    // class 2 in the top two bits marks the multiply group
    typedef struct packed {
        logic [1:0] op_class;
        logic [2:0] op_sel;
    } alu_op_fields_t;

    typedef union packed {
        alu_op_e        code;  // full decode for the result select
        alu_op_fields_t f;     // coarse decode for the control path
    } alu_op_word_u;

    // layout of the operation register as written by the CPU
    typedef struct packed {
        logic [1:0]   pad;
        logic         cin_n;  // low means carry in
        alu_op_word_u op;
    } alu_cmd_t;

    // flags are stored inverted so a low bit means the condition holds
    typedef struct packed {
        logic c_n;
        logic z_n;
        logic n_n;
        logic o_n;
        logic gt_n;
        logic lt_n;
        logic eq_n;
        logic ne_n;
    } alu_flags_t;

    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [2:0]        adr;
        logic [`ALU_W-1:0] dat_w;
    } wb_req_t;

endpackage

`default_nettype wire

//--- alu_defs.svh
`ifndef ALU_DEFS_SVH
`define ALU_DEFS_SVH

// datapath width of the coprocessor, every operand and result is one byte
`define ALU_W 8

// byte register map on the 3-bit bus address
`define ALU_ADDR_A     3'd0
`define ALU_ADDR_B     3'd1
`define ALU_ADDR_OP    3'd2  // writing here launches the operation
`define ALU_ADDR_RES   3'd3  // read only
`define ALU_ADDR_FLAGS 3'd4  // read only, flags are active low

`define ALU_MUL_STEPS 8  // one shift-add step per multiplier bit

`define ALU_OP_RESET    8'h20  // pass A with cin_n high
`define ALU_FLAGS_RESET 8'hFF  // every flag inactive

`endif
